// ==== ad5676_dac_ctrl.f ====
+incdir+include
source/ad5676_pkg.sv
source/dac_pair_if.sv
source/cmd_sequencer.sv
source/dac_cal_unit.sv
source/dac_spi_tx.sv
source/ad5676_dac_ctrl.sv
tests/ad5676_dac_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module ad5676_dac_ctrl_tb -Mdir obj_dir -f ad5676_dac_ctrl.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vad5676_dac_ctrl_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit 1
fi
exit 0

// ==== tests/ad5676_dac_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "ad5676_consts.svh"

module ad5676_dac_ctrl_tb;

  localparam int max_cycles = 20000; // About twice the summed test lengths
  localparam int write_delay = 40;   // Runs out long before the four pairs are sent

  logic        clk = 1'b0;
  logic        resetn;
  logic [31:0] cmd_word;
  logic        cmd_buf_empty;
  logic        cmd_word_rd_en;
  logic        trigger;
  logic        ldac_shared;
  logic        waiting_for_trig;
  logic        unexp_trig;
  logic        cmd_buf_underflow;
  logic        cal_oob;
  logic        dac_val_oob;
  logic        n_cs;
  logic        mosi;
  logic        ldac;

  logic [31:0]        fifo_q [$];     // Show-ahead command FIFO model
  logic [23:0]        expected_q [$]; // SPI words in send order
  logic [23:0]        captured_q [$];
  logic signed [15:0] cal_model [8];  // Calibration the DUT should hold
  logic [31:0]        lfsr_state = 32'h77c0;
  logic               pop_seen;       // rd_en sampled at the last falling edge
  logic [23:0]        cap_word = '0;
  int                 cap_bits = 0;
  int                 ldac_pulses = 0;
  int                 cycle_cnt = 0;
  int                 ldac_before;

  ad5676_dac_ctrl dut0 (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .cmd_word_rd_en,
    .trigger, .ldac_shared, .waiting_for_trig, .unexp_trig,
    .cmd_buf_underflow, .cal_oob, .dac_val_oob, .n_cs, .mosi, .ldac
  );

  always #50 clk = ~clk; // 100 ns period

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Code kept at least CAL_MAX away from both ends of the range
  task automatic random_code(output logic [15:0] code);
    logic [15:0] raw;
    raw = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // One step per bit
      raw = {raw[14:0], lfsr_state[0]};
    end
    code = 16'(`AD5676_CAL_MAX + raw % (65535 - 2 * `AD5676_CAL_MAX));
  endtask

  // Expected write word is opcode then 0 then channel then calibrated code
  function automatic logic [23:0] expected_word(input int ch, input logic [15:0] code,
                                                input logic signed [15:0] cal);
    logic [15:0] sum;
    sum = code + cal;
    return {`AD5676_SPI_WRITE, 1'b0, 3'(ch), sum};
  endfunction

  function automatic logic [31:0] ctrl_cmd(input ad5676_pkg::cmd_kind_e kind,
                                           input logic trig, input logic cont,
                                           input logic do_ldac, input int delay);
    logic [31:0] w;
    w = '0;
    w[`AD5676_KIND_MSB:`AD5676_KIND_LSB] = kind;
    w[`AD5676_TRIG_BIT] = trig;
    w[`AD5676_CONT_BIT] = cont;
    w[`AD5676_LDAC_BIT] = do_ldac;
    w[`AD5676_DELAY_WIDTH-1:0] = `AD5676_DELAY_WIDTH'(delay);
    return w;
  endfunction

  function automatic logic [31:0] cal_cmd(input int ch, input logic [15:0] value);
    logic [31:0] w;
    w = '0;
    w[`AD5676_KIND_MSB:`AD5676_KIND_LSB] = ad5676_pkg::CMD_SET_CAL;
    w[`AD5676_CAL_CH_LSB +: 3] = 3'(ch);
    w[15:0] = value;
    return w;
  endfunction

  task automatic refresh_fifo();
    cmd_buf_empty = (fifo_q.size() == 0);
    cmd_word = cmd_buf_empty ? 32'h0 : fifo_q[0]; // Head shown ahead of the pop
  endtask

  task automatic push_word(input logic [31:0] w);
    fifo_q.push_back(w);
    refresh_fifo();
  endtask

  // One clock with rd_en sampled mid-cycle and inputs changed 10 ns after the edge
  task automatic step_cycle();
    @(negedge clk);
    pop_seen = cmd_word_rd_en;
    @(posedge clk);
    #10;
    if (pop_seen === 1'b1) begin
      if (fifo_q.size() == 0) stop_with_failure("Read enable seen while the FIFO was empty");
      else void'(fifo_q.pop_front());
    end
    refresh_fifo();
  endtask

  task automatic apply_reset();
    resetn = 1'b0;
    trigger = 1'b0;
    ldac_shared = 1'b0;
    fifo_q.delete();
    refresh_fifo();
    for (int ch = 0; ch < 8; ch++) cal_model[ch] = '0;
    repeat (10) step_cycle();
    resetn = 1'b1;
  endtask

  // Command plus four pairs where the pair at index good_pairs carries a raw 65535
  task automatic queue_write(input logic do_ldac, input int good_pairs);
    logic [15:0] codes [8];
    for (int ch = 0; ch < 8; ch++) random_code(codes[ch]);
    push_word(ctrl_cmd(ad5676_pkg::CMD_DAC_WR, 1'b0, 1'b0, do_ldac, write_delay));
    for (int p = 0; p < 4; p++) begin
      if (p == good_pairs) codes[2*p] = 16'hffff;
      if (p < good_pairs) begin
        expected_q.push_back(expected_word(2*p, codes[2*p], cal_model[2*p]));
        expected_q.push_back(expected_word(2*p+1, codes[2*p+1], cal_model[2*p+1]));
      end
      push_word({codes[2*p+1], codes[2*p]}); // Low half is the even channel
    end
  endtask

  // SPI capture at the falling edge where mosi is stable
  always @(negedge clk) begin
    if (n_cs) begin
      cap_bits = 0; // Drops a word cut short by a halt
    end else begin
      cap_word = {cap_word[22:0], mosi}; // MSB first
      cap_bits++;
      if (cap_bits == `AD5676_SPI_BITS) begin
        captured_q.push_back(cap_word);
        cap_bits = 0;
      end
    end
  end

  always @(negedge clk) if (ldac) ldac_pulses++;

  // Compare captured words in order
  always @(posedge clk) begin : compare_words
    logic [23:0] got;
    if (captured_q.size() != 0) begin
      got = captured_q.pop_front();
      if (expected_q.size() == 0) stop_with_failure($sformatf("Unexpected SPI word 0x%h", got));
      else compare_value("spi_word", 32'(got), 32'(expected_q.pop_front()));
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) stop_with_failure("Timeout, the run did not finish in time");
  end

  initial begin
    resetn = 1'b0;
    cmd_word = '0;
    cmd_buf_empty = 1'b1;
    trigger = 1'b0;
    ldac_shared = 1'b0;
    pop_seen = 1'b0;
    apply_reset();

    // Quiet outputs after reset
    compare_value("n_cs", 32'(n_cs), 1);
    compare_value("mosi", 32'(mosi), 0);
    compare_value("ldac", 32'(ldac), 0);
    compare_value("waiting_for_trig", 32'(waiting_for_trig), 0);
    compare_value("unexp_trig", 32'(unexp_trig), 0);
    compare_value("cmd_buf_underflow", 32'(cmd_buf_underflow), 0);
    compare_value("cal_oob", 32'(cal_oob), 0);
    compare_value("dac_val_oob", 32'(dac_val_oob), 0);

    // Write with LDAC and then one without
    ldac_before = ldac_pulses;
    queue_write(1'b1, 4);
    while (expected_q.size() != 0) step_cycle();
    while (ldac_pulses == ldac_before) step_cycle();
    repeat (50) step_cycle();
    compare_value("ldac_pulses", 32'(ldac_pulses - ldac_before), 1);
    ldac_before = ldac_pulses;
    queue_write(1'b0, 4);
    while (expected_q.size() != 0) step_cycle();
    repeat (60) step_cycle();
    compare_value("ldac_pulses", 32'(ldac_pulses - ldac_before), 0);

    // Calibration spread over the full range with ch 0 at -CAL_MAX
    for (int ch = 0; ch < 8; ch++) begin
      cal_model[ch] = 16'(ch * 1170 - `AD5676_CAL_MAX);
      push_word(cal_cmd(ch, cal_model[ch]));
    end
    queue_write(1'b0, 4);
    while (expected_q.size() != 0) step_cycle();
    repeat (60) step_cycle();
    compare_value("cal_oob", 32'(cal_oob), 0);

    // Trigger wait ended by the trigger
    ldac_before = ldac_pulses;
    push_word(ctrl_cmd(ad5676_pkg::CMD_NO_OP, 1'b1, 1'b0, 1'b1, 0));
    while (!waiting_for_trig) step_cycle();
    trigger = 1'b1;
    step_cycle();
    trigger = 1'b0;
    compare_value("waiting_for_trig", 32'(waiting_for_trig), 0);
    repeat (5) step_cycle();
    compare_value("ldac_pulses", 32'(ldac_pulses - ldac_before), 1);

    // Trigger wait ended by a cancel
    ldac_before = ldac_pulses;
    push_word(ctrl_cmd(ad5676_pkg::CMD_NO_OP, 1'b1, 1'b0, 1'b1, 0));
    while (!waiting_for_trig) step_cycle();
    push_word(ctrl_cmd(ad5676_pkg::CMD_CANCEL, 1'b0, 1'b0, 1'b0, 0));
    while (waiting_for_trig) step_cycle();
    repeat (5) step_cycle();
    compare_value("ldac_pulses", 32'(ldac_pulses - ldac_before), 0);
    compare_value("cmd_buf_empty", 32'(cmd_buf_empty), 1);
    compare_value("unexp_trig", 32'(unexp_trig), 0);

    // Trigger in idle halts everything
    apply_reset();
    trigger = 1'b1;
    step_cycle();
    trigger = 1'b0;
    compare_value("unexp_trig", 32'(unexp_trig), 1);
    push_word(ctrl_cmd(ad5676_pkg::CMD_DAC_WR, 1'b0, 1'b0, 1'b1, write_delay));
    repeat (100) begin
      step_cycle();
      compare_value("n_cs", 32'(n_cs), 1);
      compare_value("cmd_word_rd_en", 32'(pop_seen), 0);
    end

    // Shared LDAC while a write runs keeps the pairs in the FIFO
    apply_reset();
    queue_write(1'b0, 0);
    do step_cycle(); while (pop_seen !== 1'b1);
    ldac_shared = 1'b1;
    step_cycle();
    ldac_shared = 1'b0;
    compare_value("unexp_trig", 32'(unexp_trig), 1);
    compare_value("cmd_word_rd_en", 32'(pop_seen), 0);
    repeat (40) begin
      step_cycle();
      compare_value("n_cs", 32'(n_cs), 1);
      compare_value("cmd_word_rd_en", 32'(pop_seen), 0);
    end
    compare_value("fifo_words_left", 32'(fifo_q.size()), 4);

    // Calibration beyond CAL_MAX
    apply_reset();
    push_word(cal_cmd(3, 16'd5000));
    while (!cal_oob) step_cycle();
    compare_value("unexp_trig", 32'(unexp_trig), 0);

    // Raw 65535 in the second pair lets only the first pair go out
    apply_reset();
    queue_write(1'b0, 1);
    while (!dac_val_oob) step_cycle();
    compare_value("expected_words_left", 32'(expected_q.size()), 0);
    repeat (60) begin
      step_cycle();
      compare_value("n_cs", 32'(n_cs), 1);
    end

    // Continue bit with nothing behind it
    apply_reset();
    push_word(ctrl_cmd(ad5676_pkg::CMD_NO_OP, 1'b0, 1'b1, 1'b0, 20));
    while (!cmd_buf_underflow) step_cycle();
    compare_value("unexp_trig", 32'(unexp_trig), 0);
    compare_value("dac_val_oob", 32'(dac_val_oob), 0);

    if (expected_q.size() != 0 || captured_q.size() != 0) begin
      stop_with_failure("SPI words left unchecked at the end of the run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== source/ad5676_dac_ctrl.sv ====
`timescale 1ns/100ps

module ad5676_dac_ctrl (
  input  logic        clk,
  input  logic        resetn,
  input  logic [31:0] cmd_word,      // Show-ahead FIFO head
  input  logic        cmd_buf_empty,
  output logic        cmd_word_rd_en,
  input  logic        trigger,
  input  logic        ldac_shared,
  output logic        waiting_for_trig,
  output logic        unexp_trig,
  output logic        cmd_buf_underflow,
  output logic        cal_oob,
  output logic        dac_val_oob,
  output logic        n_cs,
  output logic        mosi,
  output logic        ldac
);

  dac_pair_if pair_bus ();

  logic                     halt;
  logic                     cal_we;
  ad5676_pkg::dac_channel_t cal_channel;
  ad5676_pkg::cal_value_t   cal_value;
  logic                     frame_load;
  ad5676_pkg::spi_pair_t    frame;
  logic                     pair_sent;

  cmd_sequencer seq0 (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .cmd_word_rd_en,
    .trigger, .ldac_shared, .waiting_for_trig, .ldac,
    .unexp_trig, .cmd_buf_underflow, .cal_oob, .dac_val_oob,
    .pair_sent, .halt, .cal_we, .cal_channel, .cal_value,
    .pair (pair_bus.seq)
  );

  dac_cal_unit cal0 (
    .clk, .resetn, .halt, .cal_we, .cal_channel, .cal_value,
    .pair (pair_bus.cal),
    .frame_load, .frame, .cal_oob, .dac_val_oob
  );

  dac_spi_tx spi0 (
    .clk, .resetn, .halt, .frame_load, .frame, .n_cs, .mosi, .pair_sent
  );

endmodule

// ==== source/dac_spi_tx.sv ====
`timescale 1ns/100ps
`include "ad5676_consts.svh"

module dac_spi_tx (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  halt,
  input  logic                  frame_load,
  input  ad5676_pkg::spi_pair_t frame,
  output logic                  n_cs,
  output logic                  mosi,
  output logic                  pair_sent
);

  localparam int pair_bits = $bits(ad5676_pkg::spi_pair_t);
  localparam logic [4:0] gap_cycles = 5'(`AD5676_N_CS_HIGH);
  localparam logic [4:0] word_bits = 5'(`AD5676_SPI_BITS);

  logic [pair_bits-1:0] shreg;   // Both words, MSB out first
  logic [4:0]           gap_cnt; // n_cs high time left before a word
  logic [4:0]           bit_cnt; // Bits left in the current word
  logic                 second_word;

  assign mosi = !n_cs && shreg[pair_bits-1]; // Quiet while deselected

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      n_cs        <= 1'b1;
      gap_cnt     <= '0;
      bit_cnt     <= '0;
      second_word <= 1'b0;
      pair_sent   <= 1'b0;
    end else begin
      pair_sent <= 1'b0;
      if (frame_load) begin
        gap_cnt     <= gap_cycles;
        second_word <= 1'b0;
      end else if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
        if (gap_cnt == 5'd1) begin
          n_cs    <= 1'b0; // High time met, select the DAC
          bit_cnt <= word_bits;
        end
      end else if (bit_cnt != '0) begin
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == 5'd1) begin
          n_cs <= 1'b1;
          if (second_word) begin
            pair_sent <= 1'b1;
          end else begin
            gap_cnt     <= gap_cycles; // Spacing before the second word
            second_word <= 1'b1;
          end
        end
      end
    end
  end

  // Shift one bit per selected cycle
  always_ff @(posedge clk) begin
    if (frame_load) shreg <= frame;
    else if (!n_cs) shreg <= {shreg[pair_bits-2:0], 1'b0};
  end

  a_cs_low_max: assert property (@(posedge clk) disable iff (!resetn)
    $fell(n_cs) |-> ##[1:word_bits] n_cs);

endmodule

// ==== source/dac_cal_unit.sv ====
`timescale 1ns/100ps
`include "ad5676_consts.svh"

module dac_cal_unit (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     halt,
  input  logic                     cal_we,
  input  ad5676_pkg::dac_channel_t cal_channel,
  input  ad5676_pkg::cal_value_t   cal_value,
  dac_pair_if.cal                  pair,
  output logic                     frame_load,
  output ad5676_pkg::spi_pair_t    frame,
  output logic                     cal_oob,
  output logic                     dac_val_oob
);

  localparam ad5676_pkg::cal_value_t cal_max = ad5676_pkg::cal_value_t'(`AD5676_CAL_MAX);
  localparam logic signed [17:0] code_max = 18'(2 * `AD5676_CODE_ZERO); // 65534

  ad5676_pkg::cal_value_t   cal_tab [8];
  ad5676_pkg::dac_channel_t ch_hi;
  ad5676_pkg::dac_channel_t s1_channel;
  logic signed [17:0]       s1_sum_lo;  // Room for code plus or minus a full calibration
  logic signed [17:0]       s1_sum_hi;
  logic                     s1_valid;
  logic                     s1_raw_bad; // A raw 65535 in either half
  logic                     s1_sum_bad;
  logic                     cal_in_range;

  function automatic logic signed [17:0] cal_sum(ad5676_pkg::dac_code_t code,
                                                 ad5676_pkg::cal_value_t cal);
    return $signed({2'b00, code}) + 18'(cal);
  endfunction

  function automatic ad5676_pkg::spi_word_t write_word(ad5676_pkg::dac_channel_t ch,
                                                        logic signed [17:0] sum);
    return {`AD5676_SPI_WRITE, 1'b0, ch, sum[15:0]};
  endfunction

  assign ch_hi = pair.channel + 3'd1;
  assign cal_in_range = (cal_value <= cal_max) && (cal_value >= -cal_max);
  assign s1_sum_bad = s1_sum_lo < 0 || s1_sum_lo > code_max
                      || s1_sum_hi < 0 || s1_sum_hi > code_max;

  // Table starts at zero and bad writes leave it as it is
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < 8; i++) begin
        cal_tab[i] <= '0;
      end
      cal_oob <= 1'b0;
    end else if (cal_we && !halt) begin
      if (cal_in_range) cal_tab[cal_channel] <= cal_value;
      else cal_oob <= 1'b1;
    end
  end

  // Stage 1 registers the calibrated sums
  always_ff @(posedge clk) begin
    if (!resetn) s1_valid <= 1'b0;
    else s1_valid <= pair.load && !halt;
  end

  always_ff @(posedge clk) begin
    if (pair.load) begin
      s1_channel <= pair.channel;
      s1_sum_lo  <= cal_sum(pair.code_lo, cal_tab[pair.channel]);
      s1_sum_hi  <= cal_sum(pair.code_hi, cal_tab[ch_hi]);
      s1_raw_bad <= (pair.code_lo == 16'hffff) || (pair.code_hi == 16'hffff);
    end
  end

  // Stage 2 checks the bounds and builds the frame
  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_load  <= 1'b0;
      dac_val_oob <= 1'b0;
    end else begin
      frame_load <= s1_valid && !s1_raw_bad && !s1_sum_bad && !halt;
      if (s1_valid && !halt && (s1_raw_bad || s1_sum_bad)) dac_val_oob <= 1'b1; // No frame
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      frame.first  <= write_word(s1_channel, s1_sum_lo);
      frame.second <= write_word(s1_channel + 3'd1, s1_sum_hi);
    end
  end

  // The sequencer loads no pair once it has halted
  a_no_load_in_halt: assert property (@(posedge clk) disable iff (!resetn)
    !(halt && pair.load));

endmodule

// ==== source/cmd_sequencer.sv ====
`timescale 1ns/100ps
`include "ad5676_consts.svh"

module cmd_sequencer (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [31:0]              cmd_word,
  input  logic                     cmd_buf_empty,
  output logic                     cmd_word_rd_en,
  input  logic                     trigger,
  input  logic                     ldac_shared,
  output logic                     waiting_for_trig,
  output logic                     ldac,
  output logic                     unexp_trig,
  output logic                     cmd_buf_underflow,
  input  logic                     cal_oob,
  input  logic                     dac_val_oob,
  input  logic                     pair_sent,
  output logic                     halt,
  output logic                     cal_we,
  output ad5676_pkg::dac_channel_t cal_channel,
  output ad5676_pkg::cal_value_t   cal_value,
  dac_pair_if.seq                  pair
);

  ad5676_pkg::cmd_kind_e  kind;
  ad5676_pkg::seq_state_e state;
  logic [`AD5676_DELAY_WIDTH-1:0] delay_timer;
  logic       do_ldac;     // Latched command bits
  logic       wait_trig;
  logic       expect_next;
  logic [1:0] pair_cnt;    // Pairs sent in the current write
  logic       pair_due;    // Next pair is to be popped this cycle
  logic       finish;      // Running wait ends
  logic       cancel;
  logic       take;        // Pop and start the next command
  logic       pair_pop;
  logic       trig_err;
  logic       under_err;
  logic       err;

  assign kind = ad5676_pkg::cmd_kind_e'(cmd_word[`AD5676_KIND_MSB:`AD5676_KIND_LSB]);
  assign halt = (state == ad5676_pkg::S_ERROR);
  assign waiting_for_trig = (state == ad5676_pkg::S_TRIG_WAIT);

  // A wait ends on timer expiry or on the trigger it waits for
  assign finish = (state == ad5676_pkg::S_DELAY && delay_timer == '0)
                  || (state == ad5676_pkg::S_TRIG_WAIT && trigger);

  // Error sources, only new ones count once halted
  assign trig_err = !halt && ((trigger && state != ad5676_pkg::S_TRIG_WAIT)
                              || (ldac_shared && state == ad5676_pkg::S_DAC_WR));
  assign under_err = !halt && cmd_buf_empty && ((finish && expect_next) || pair_due);
  assign err = trig_err || under_err || (!halt && (cal_oob || dac_val_oob));

  // Cancel only applies to a wait in progress
  assign cancel = (state == ad5676_pkg::S_DELAY || state == ad5676_pkg::S_TRIG_WAIT)
                  && !cmd_buf_empty && kind == ad5676_pkg::CMD_CANCEL && !err;
  assign take = (state == ad5676_pkg::S_IDLE || finish) && !cmd_buf_empty && !cancel && !err;
  assign pair_pop = pair_due && !cmd_buf_empty && !err;
  assign cmd_word_rd_en = take || cancel || pair_pop; // Never while empty

  assign cal_we = take && kind == ad5676_pkg::CMD_SET_CAL;
  assign cal_channel = cmd_word[`AD5676_CAL_CH_LSB +: 3];
  assign cal_value = cmd_word[15:0];

  // Pair word goes straight to the calibration pipeline
  assign pair.load = pair_pop;
  assign pair.channel = {pair_cnt, 1'b0};
  assign pair.code_lo = cmd_word[15:0];
  assign pair.code_hi = cmd_word[31:16];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ad5676_pkg::S_IDLE;
    end else if (err) begin
      state <= ad5676_pkg::S_ERROR;
    end else if (cancel) begin
      state <= ad5676_pkg::S_IDLE;
    end else if (take) begin
      case (kind)
        ad5676_pkg::CMD_NO_OP:
          state <= cmd_word[`AD5676_TRIG_BIT] ? ad5676_pkg::S_TRIG_WAIT : ad5676_pkg::S_DELAY;
        ad5676_pkg::CMD_DAC_WR: state <= ad5676_pkg::S_DAC_WR;
        default: state <= ad5676_pkg::S_IDLE; // SET_CAL and CANCEL finish at once
      endcase
    end else if (finish) begin
      state <= ad5676_pkg::S_IDLE; // Nothing queued and none expected
    end else if (state == ad5676_pkg::S_DAC_WR && pair_sent && pair_cnt == 2'd3) begin
      state <= wait_trig ? ad5676_pkg::S_TRIG_WAIT : ad5676_pkg::S_DELAY; // All eight sent
    end
  end

  // Command bits and delay timer, loaded when the command is popped
  always_ff @(posedge clk) begin
    if (!resetn) begin
      do_ldac     <= 1'b0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
      delay_timer <= '0;
    end else if (take && (kind == ad5676_pkg::CMD_NO_OP || kind == ad5676_pkg::CMD_DAC_WR)) begin
      do_ldac     <= cmd_word[`AD5676_LDAC_BIT];
      wait_trig   <= cmd_word[`AD5676_TRIG_BIT];
      expect_next <= cmd_word[`AD5676_CONT_BIT];
      delay_timer <= cmd_word[`AD5676_TRIG_BIT] ? '0 : cmd_word[`AD5676_DELAY_WIDTH-1:0];
    end else if (delay_timer != '0) begin
      delay_timer <= delay_timer - 1'b1; // Runs during the SPI transfers too
    end
  end

  // First pair right after the command, later ones after each pair_sent
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pair_due <= 1'b0;
      pair_cnt <= '0;
    end else begin
      pair_due <= !err && ((take && kind == ad5676_pkg::CMD_DAC_WR)
                           || (state == ad5676_pkg::S_DAC_WR && pair_sent && pair_cnt != 2'd3));
      if (take && kind == ad5676_pkg::CMD_DAC_WR) begin
        pair_cnt <= '0;
      end else if (state == ad5676_pkg::S_DAC_WR && pair_sent) begin
        pair_cnt <= pair_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      unexp_trig        <= 1'b0;
      cmd_buf_underflow <= 1'b0;
      ldac              <= 1'b0;
    end else begin
      if (trig_err) unexp_trig <= 1'b1; // Sticky
      if (under_err) cmd_buf_underflow <= 1'b1;
      ldac <= finish && do_ldac && !cancel && !err; // One-cycle pulse, none on cancel
    end
  end

  // ERROR is only entered through err, which also blocks the pulse
  a_no_ldac_in_halt: assert property (@(posedge clk) disable iff (!resetn) !(ldac && halt));

endmodule

// ==== source/dac_pair_if.sv ====
`timescale 1ns/100ps

// One FIFO word split into two adjacent channel codes
interface dac_pair_if;

  logic                     load;    // One-cycle strobe per popped pair
  ad5676_pkg::dac_channel_t channel; // Even channel, code_hi goes to channel+1
  ad5676_pkg::dac_code_t    code_lo;
  ad5676_pkg::dac_code_t    code_hi;

  modport seq (
    output load,
    output channel,
    output code_lo,
    output code_hi
  );

  modport cal (
    input load,
    input channel,
    input code_lo,
    input code_hi
  );

endinterface

// ==== source/ad5676_pkg.sv ====
package ad5676_pkg;

  // Command kind, bits 31..30 of the command word
  typedef enum logic [1:0] {
    CMD_NO_OP   = 2'b00, // Delay or trigger wait only
    CMD_DAC_WR  = 2'b01, // Four channel pairs follow in the FIFO
    CMD_SET_CAL = 2'b10,
    CMD_CANCEL  = 2'b11  // Ends a delay or trigger wait without LDAC
  } cmd_kind_e;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_DAC_WR,
    S_ERROR // Sticky until reset
  } seq_state_e;

  // Offset code, 32767 is zero and 65535 is rejected
  typedef logic [15:0] dac_code_t;

  typedef logic signed [15:0] cal_value_t; // Per-channel signed calibration
  typedef logic [2:0] dac_channel_t;
  typedef logic [23:0] spi_word_t; // Opcode, 0, channel, code

  // Two words per pair, first one shifted out first
  typedef struct packed {
    spi_word_t first;
    spi_word_t second;
  } spi_pair_t;

endpackage

// ==== include/ad5676_consts.svh ====
`ifndef AD5676_CONSTS_SVH
`define AD5676_CONSTS_SVH

// Command word fields
`define AD5676_KIND_MSB 31
`define AD5676_KIND_LSB 30
`define AD5676_TRIG_BIT 29 // Wait for trigger at the end of the command
`define AD5676_CONT_BIT 28 // Another command must follow
`define AD5676_LDAC_BIT 27 // Pulse ldac when the command completes
`define AD5676_DELAY_WIDTH 25 // Delay in bits 24..0
`define AD5676_CAL_CH_LSB 16 // Calibration channel in bits 18..16

// SPI framing
`define AD5676_SPI_WRITE 4'b0001 // Write input register, update on LDAC
`define AD5676_SPI_BITS 24

// Minimum n_cs high time in clocks, 42 cycle word period at 50 MHz minus 24 bits
`define AD5676_N_CS_HIGH 18

// Bounds
`define AD5676_CAL_MAX 4096 // Largest calibration magnitude
`define AD5676_CODE_ZERO 32767 // Mid-scale offset code

`endif
